/* logic/video_pkg.sv */
////////////////////////////////////////
// video package
// raster constants, field widths and the
// shared structs of the XVGA video path
////////////////////////////////////////
`default_nettype none

package video_pkg;

   // field widths
   localparam int H_W = 11;
   localparam int V_W = 10;
   localparam int ADDR_W = 19;
   localparam int PIX_W = 18;
   localparam int LANE_W = 9;
   localparam int LANES = 4;
   localparam int DEBOUNCE_CYCLES = 64;
   localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES);

   typedef logic [H_W-1:0] hcount_t;
   typedef logic [V_W-1:0] vcount_t;
   typedef logic [ADDR_W-1:0] vram_addr_t;
   typedef logic [PIX_W-1:0] pixel18_t;
   typedef logic [1:0] filter_opt_t;
   typedef logic [DEBOUNCE_W-1:0] debounce_cnt_t;

   ////////////////////////////////////////
   // raster points, 1024 x 768 at 60 Hz
   ////////////////////////////////////////
   localparam hcount_t H_ACTIVE = 11'd1024;
   localparam hcount_t H_SYNC_ON = 11'd1048;
   localparam hcount_t H_SYNC_OFF = 11'd1184;
   localparam hcount_t H_TOTAL = 11'd1344;
   localparam vcount_t V_ACTIVE = 10'd768;
   localparam vcount_t V_SYNC_ON = 10'd777;
   localparam vcount_t V_SYNC_OFF = 10'd783;
   localparam vcount_t V_TOTAL = 10'd806;

   // memory read forecast distance in pixels
   localparam hcount_t FETCH_AHEAD = 11'd8;

   // inclusive frame window
   localparam hcount_t FRAME_H_MIN = 11'd35;
   localparam hcount_t FRAME_H_MAX = 11'd743;
   localparam vcount_t FRAME_V_MIN = 10'd79;
   localparam vcount_t FRAME_V_MAX = 10'd563;

   // last count of a stable button level
   localparam debounce_cnt_t DEBOUNCE_LAST = debounce_cnt_t'(DEBOUNCE_CYCLES - 1);

   typedef struct packed {
      hcount_t hcount;
      vcount_t vcount;
      logic hsync;
      logic vsync;
      logic blank;
   } raster_t;

   // upper pixel goes out first
   typedef struct packed {
      pixel18_t hi;
      pixel18_t lo;
   } pixel_pair_t;

   // one memory word, pixels on read, pattern lanes on write
   typedef union packed {
      pixel_pair_t pix;
      logic [LANES-1:0][LANE_W-1:0] lane;
   } vram_word_u;

   typedef struct packed {
      vram_addr_t addr;
      logic we;
      vram_word_u wdata;
   } vram_req_t;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
      logic hsync;
      logic vsync;
      logic blank_b;
   } vga_out_t;

endpackage

`default_nettype wire

/* logic/display_timing.sv */
////////////////////////////////////////
// display timing
// XVGA raster counters over a 1344 x 806
// total, active-low syncs and blank
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module display_timing (
   input wire logic clk,
   input wire logic rst_n,
   output video_pkg::raster_t raster
);

   video_pkg::hcount_t hcount;
   video_pkg::vcount_t vcount;
   logic hsync;
   logic vsync;
   logic hblank;
   logic vblank;
   logic blank;

   // line and frame events, all on the last cycle of something
   logic hreset;
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic vreset;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;
   logic next_hblank;
   logic next_vblank;

   assign hreset = (hcount == video_pkg::H_TOTAL - 1'b1);
   assign hblank_on = (hcount == video_pkg::H_ACTIVE - 1'b1);
   assign hsync_on = (hcount == video_pkg::H_SYNC_ON - 1'b1);
   assign hsync_off = (hcount == video_pkg::H_SYNC_OFF - 1'b1);

   // vertical events fire at the line end
   assign vreset = hreset && (vcount == video_pkg::V_TOTAL - 1'b1);
   assign vblank_on = hreset && (vcount == video_pkg::V_ACTIVE - 1'b1);
   assign vsync_on = hreset && (vcount == video_pkg::V_SYNC_ON - 1'b1);
   assign vsync_off = hreset && (vcount == video_pkg::V_SYNC_OFF - 1'b1);

   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
         hblank <= 1'b0;
         vblank <= 1'b0;
         blank <= 1'b0;
      end else begin
         hcount <= hreset ? '0 : hcount + 1'b1;
         if (hreset) begin
            vcount <= vreset ? '0 : vcount + 1'b1;
         end
         // active low, held between on and off events
         hsync <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         hblank <= next_hblank;
         vblank <= next_vblank;
         blank <= next_vblank | (next_hblank & ~hreset);
      end
   end

   assign raster = '{hcount: hcount, vcount: vcount, hsync: hsync, vsync: vsync, blank: blank};

   a_raster_range: assert property (@(posedge clk) disable iff (!rst_n)
      (hcount < video_pkg::H_TOTAL) && (vcount < video_pkg::V_TOTAL))
      else $error("raster counter out of range");

endmodule

`default_nettype wire

/* logic/vram_fetch.sv */
////////////////////////////////////////
// video memory fetch
// forecasts the read address 8 pixels
// ahead and unpacks two pixels per word
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vram_fetch (
   input wire logic clk,
   input wire logic rst_n,
   input video_pkg::raster_t raster,
   input video_pkg::vram_word_u rdata,
   output video_pkg::vram_addr_t rd_addr,
   output video_pkg::pixel18_t pixel
);

   localparam video_pkg::hcount_t H_WRAP = video_pkg::H_TOTAL - video_pkg::FETCH_AHEAD;

   video_pkg::hcount_t hcount_f;
   video_pkg::vcount_t vcount_f;
   logic line_wrap;
   video_pkg::vram_word_u word_latched;
   video_pkg::vram_word_u word_shown;

   ////////////////////////////////////////
   // address forecast
   ////////////////////////////////////////

   // near the line end the forecast lands on the next line
   assign line_wrap = (raster.hcount >= H_WRAP);
   assign hcount_f = line_wrap ? raster.hcount - H_WRAP : raster.hcount + video_pkg::FETCH_AHEAD;

   always_comb begin
      vcount_f = raster.vcount;
      if (line_wrap) begin
         // and past the last line onto line 0
         if (raster.vcount == video_pkg::V_TOTAL - 1'b1) begin
            vcount_f = '0;
         end else begin
            vcount_f = raster.vcount + 1'b1;
         end
      end
   end

   // one word holds a pixel pair, so the pixel count is halved
   assign rd_addr = {vcount_f, hcount_f[9:1]};

   ////////////////////////////////////////
   // word capture and unpack
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      // returning word is caught on even pixels
      if (!raster.hcount[0]) begin
         word_latched <= rdata;
      end
      // and moved to the display register on odd ones
      if (raster.hcount[0]) begin
         word_shown <= word_latched;
      end
   end

   // upper half on even pixels, lower half on odd
   assign pixel = raster.hcount[0] ? word_shown.pix.lo : word_shown.pix.hi;

   a_fetch_line: assert property (@(posedge clk) disable iff (!rst_n)
      rd_addr[18:9] < video_pkg::V_TOTAL)
      else $error("forecast line out of range");

endmodule

`default_nettype wire

/* logic/vram_port.sv */
////////////////////////////////////////
// video memory port
// writes a counter pattern during blank
// and passes display reads otherwise
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vram_port (
   input wire logic clk,
   input wire logic rst_n,
   input video_pkg::raster_t raster,
   input video_pkg::vram_addr_t rd_addr,
   input wire logic pattern_fine,
   output video_pkg::vram_req_t req
);

   logic [31:0] pat_count;
   logic [3:0] pat_nibble;
   logic [video_pkg::LANE_W-1:0] pat_lane;

   // free-running pattern counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pat_count <= '0;
      end else begin
         pat_count <= pat_count + 32'd1;
      end
   end

   ////////////////////////////////////////
   // pattern word
   ////////////////////////////////////////

   // fine stripes use the lower counter bits
   assign pat_nibble = pattern_fine ? pat_count[6:3] : pat_count[7:4];

   // top lane bit unused, low four bits stay zero
   assign pat_lane = {1'b0, pat_nibble, 4'b0000};

   ////////////////////////////////////////
   // request mux
   ////////////////////////////////////////
   always_comb begin
      // same lane pattern repeated across the word
      for (int i = 0; i < video_pkg::LANES; i++) begin
         req.wdata.lane[i] = pat_lane;
      end
      // writes own the bus whenever the screen is blank
      req.we = raster.blank;
      if (raster.blank) begin
         req.addr = pat_count[18:0];
      end else begin
         // display reads the rest of the time
         req.addr = rd_addr;
      end
   end

endmodule

`default_nettype wire

/* logic/filter_command.sv */
////////////////////////////////////////
// filter command
// debounced pushbutton that latches the
// filter option from the switches
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module filter_command (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic button_n,
   input wire logic [3:0] command,
   output video_pkg::filter_opt_t option
);

   logic btn_meta;
   logic btn_sync;
   logic btn_sample;
   logic btn_clean;
   logic btn_clean_d;
   video_pkg::debounce_cnt_t stable_cnt;
   logic press;
   logic is_filter_cmd;

   ////////////////////////////////////////
   // debounce
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         btn_meta <= 1'b0;
         btn_sync <= 1'b0;
         btn_sample <= 1'b0;
         btn_clean <= 1'b0;
         btn_clean_d <= 1'b0;
         stable_cnt <= '0;
      end else begin
         // button is active low, bring it in pressed high
         btn_meta <= ~button_n;
         btn_sync <= btn_meta;
         if (btn_sync != btn_sample) begin
            // any bounce restarts the stable count
            btn_sample <= btn_sync;
            stable_cnt <= '0;
         end else if (stable_cnt == video_pkg::DEBOUNCE_LAST) begin
            btn_clean <= btn_sample;
         end else begin
            stable_cnt <= stable_cnt + 1'b1;
         end
         btn_clean_d <= btn_clean;
      end
   end

   // one cycle pulse on the clean rising edge
   assign press = btn_clean & ~btn_clean_d;

   // command 01 in the upper switch pair selects the filter
   assign is_filter_cmd = (command[3:2] == 2'b01);

   ////////////////////////////////////////
   // option register
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         option <= '0;
      end else if (press && is_filter_cmd) begin
         option <= command[1:0];
      end
   end

   a_option_on_press: assert property (@(posedge clk) disable iff (!rst_n)
      !press |=> $stable(option))
      else $error("filter option changed without a press");

endmodule

`default_nettype wire

/* logic/pixel_filter.sv */
////////////////////////////////////////
// pixel filter
// frame window, colour option and the
// registered VGA outputs
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pixel_filter (
   input wire logic clk,
   input wire logic rst_n,
   input video_pkg::raster_t raster,
   input video_pkg::pixel18_t pixel,
   input video_pkg::filter_opt_t option,
   output video_pkg::vga_out_t vga
);

   logic [7:0] red_x;
   logic [7:0] green_x;
   logic [7:0] blue_x;
   logic [7:0] red_f;
   logic [7:0] green_f;
   logic [7:0] blue_f;
   logic in_frame;

   // 6:6:6 to 8:8:8, two zero bits below
   assign red_x = {pixel[17:12], 2'b00};
   assign green_x = {pixel[11:6], 2'b00};
   assign blue_x = {pixel[5:0], 2'b00};

   // inclusive window on both axes
   assign in_frame = (raster.hcount >= video_pkg::FRAME_H_MIN)
                   && (raster.hcount <= video_pkg::FRAME_H_MAX)
                   && (raster.vcount >= video_pkg::FRAME_V_MIN)
                   && (raster.vcount <= video_pkg::FRAME_V_MAX);

   ////////////////////////////////////////
   // colour option
   ////////////////////////////////////////
   always_comb begin
      red_f = red_x;
      green_f = green_x;
      blue_f = blue_x;
      case (option)
         2'd1: begin
            // inverted on the full 8 bits, low bits end up 11
            red_f = ~red_x;
            green_f = ~green_x;
            blue_f = ~blue_x;
         end
         2'd2: begin
            green_f = '0;
            blue_f = '0;
         end
         2'd3: begin
            // grey from the green channel
            red_f = green_x;
            blue_f = green_x;
         end
         default: begin
         end
      endcase
      // outside the window everything is black, also when inverted
      if (!in_frame) begin
         red_f = '0;
         green_f = '0;
         blue_f = '0;
      end
   end

   ////////////////////////////////////////
   // output register
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vga <= '{red: 8'd0, green: 8'd0, blue: 8'd0,
                  hsync: 1'b1, vsync: 1'b1, blank_b: 1'b0};
      end else begin
         vga.red <= red_f;
         vga.green <= green_f;
         vga.blue <= blue_f;
         // syncs and blank ride along one cycle with the colour
         vga.hsync <= raster.hsync;
         vga.vsync <= raster.vsync;
         vga.blank_b <= ~raster.blank;
      end
   end

endmodule

`default_nettype wire

/* logic/video_top.sv */
////////////////////////////////////////
// video top
// XVGA raster, video memory fetch and
// pattern write, filter and VGA outputs
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_top (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic button0,
   input wire logic [7:0] switch,
   input video_pkg::vram_word_u vram_rdata,
   output video_pkg::vram_req_t vram_req,
   output video_pkg::vga_out_t vga
);

   video_pkg::raster_t raster;
   video_pkg::vram_addr_t rd_addr;
   video_pkg::pixel18_t pixel;
   video_pkg::filter_opt_t option;

   ////////////////////////////////////////
   // raster and memory
   ////////////////////////////////////////
   display_timing u_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .raster (raster)
   );

   vram_fetch u_fetch (
      .clk     (clk),
      .rst_n   (rst_n),
      .raster  (raster),
      .rdata   (vram_rdata),
      .rd_addr (rd_addr),
      .pixel   (pixel)
   );

   // switch 5 picks the finer pattern stripes
   vram_port u_port (
      .clk          (clk),
      .rst_n        (rst_n),
      .raster       (raster),
      .rd_addr      (rd_addr),
      .pattern_fine (switch[5]),
      .req          (vram_req)
   );

   ////////////////////////////////////////
   // filter control and output
   ////////////////////////////////////////

   // low switch nibble is the command, button0 locks it in
   filter_command u_command (
      .clk      (clk),
      .rst_n    (rst_n),
      .button_n (button0),
      .command  (switch[3:0]),
      .option   (option)
   );

   pixel_filter u_filter (
      .clk    (clk),
      .rst_n  (rst_n),
      .raster (raster),
      .pixel  (pixel),
      .option (option),
      .vga    (vga)
   );

endmodule

`default_nettype wire

/* testbench/zbt_model.sv */
////////////////////////////////////////
// zbt memory model
// behavioral 36-bit video memory with
// 2-cycle read and write latency
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zbt_model (
   input wire logic clk,
   input video_pkg::vram_req_t req,
   output video_pkg::vram_word_u rdata
);

   // one word per 19-bit address
   video_pkg::vram_word_u mem [0:(1 << 19) - 1];

   // request registered on the first edge
   video_pkg::vram_req_t req_d1 = '0;
   video_pkg::vram_word_u rdata_q = '0;

   always @(posedge clk) begin
      req_d1 <= req;
      // second edge, the write lands and read data comes out
      if (req_d1.we) begin
         mem[req_d1.addr] <= req_d1.wdata;
      end
      rdata_q <= mem[req_d1.addr];
   end

   assign rdata = rdata_q;

endmodule

`default_nettype wire

/* testbench/tb_video_top.sv */
////////////////////////////////////////
// video top testbench
// bouncing button presses for every
// filter option, raster and colour checks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

   logic clk;
   logic rst_n;
   logic button0;
   logic [7:0] switch;
   video_pkg::vram_word_u vram_rdata;
   video_pkg::vram_req_t vram_req;
   video_pkg::vga_out_t vga;

   integer seed;

   // option the outputs should show, only while opt_known
   logic [1:0] exp_opt;
   logic opt_known;

   // edge tracking on the registered outputs
   logic hs_d;
   logic vs_d;
   logic rst_d;
   logic hs_rise;
   logic hs_fall;
   logic vs_rise;
   logic hs_fall_seen;
   int hs_low_cnt;
   int vs_low_cnt;
   int hs_period;

   // raster position of the sample now on vga
   int pix_idx;
   int line_idx;
   logic synced;
   logic in_window;
   logic [5:0] exp_low;

   // previous memory request
   logic req_we_d;
   video_pkg::vram_addr_t req_addr_d;
   logic [8:0] exp_lane;

   // expected timing from the raster points
   int line_cycles;
   int frame_lines;
   int hsync_len;
   int vsync_len;

   assign line_cycles = int'(video_pkg::H_TOTAL);
   assign frame_lines = int'(video_pkg::V_TOTAL);
   assign hsync_len = int'(video_pkg::H_SYNC_OFF) - int'(video_pkg::H_SYNC_ON);
   assign vsync_len = (int'(video_pkg::V_SYNC_OFF) - int'(video_pkg::V_SYNC_ON)) * line_cycles;

   video_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .button0    (button0),
      .switch     (switch),
      .vram_rdata (vram_rdata),
      .vram_req   (vram_req),
      .vga        (vga)
   );

   zbt_model zbt (
      .clk   (clk),
      .req   (vram_req),
      .rdata (vram_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // output tracking
   ////////////////////////////////////////
   assign hs_rise = vga.hsync && !hs_d;
   assign hs_fall = !vga.hsync && hs_d;
   assign vs_rise = vga.vsync && !vs_d;

   // inclusive frame window on the tracked position
   assign in_window = (pix_idx >= int'(video_pkg::FRAME_H_MIN))
                    && (pix_idx <= int'(video_pkg::FRAME_H_MAX))
                    && (line_idx >= int'(video_pkg::FRAME_V_MIN))
                    && (line_idx <= int'(video_pkg::FRAME_V_MAX));

   // inverted colour leaves 11 below the 6-bit value
   assign exp_low = (exp_opt == 2'd1) ? 6'h3f : 6'h00;

   // write address is the counter, so the stripe nibble follows it
   assign exp_lane = {1'b0, (switch[5] ? vram_req.addr[6:3] : vram_req.addr[7:4]), 4'b0000};

   always @(posedge clk) begin
      rst_d <= rst_n;
      if (!rst_n) begin
         hs_d <= 1'b1;
         vs_d <= 1'b1;
         hs_low_cnt <= 0;
         vs_low_cnt <= 0;
         hs_period <= 0;
         hs_fall_seen <= 1'b0;
         pix_idx <= 0;
         line_idx <= 0;
         synced <= 1'b0;
         req_we_d <= 1'b0;
         req_addr_d <= '0;
      end else begin
         hs_d <= vga.hsync;
         vs_d <= vga.vsync;
         hs_low_cnt <= vga.hsync ? 0 : hs_low_cnt + 1;
         vs_low_cnt <= vga.vsync ? 0 : vs_low_cnt + 1;
         req_we_d <= vram_req.we;
         req_addr_d <= vram_req.addr;
         if (hs_fall) begin
            hs_period <= 1;
            hs_fall_seen <= 1'b1;
         end else begin
            hs_period <= hs_period + 1;
         end
         // vsync rise marks pixel 0 of line 783
         if (vs_rise) begin
            pix_idx <= 1;
            line_idx <= int'(video_pkg::V_SYNC_OFF);
            synced <= 1'b1;
         end else if (pix_idx == line_cycles - 1) begin
            pix_idx <= 0;
            line_idx <= (line_idx == frame_lines - 1) ? 0 : line_idx + 1;
         end else begin
            pix_idx <= pix_idx + 1;
         end
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("sim failed");
      $fatal(1, "check failed");
   endtask

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   always @(posedge clk) begin
      if (rst_n && !rst_d) begin
         // first sample out of reset
         assert (!vga.blank_b && vga.hsync && vga.vsync
                 && vga.red == 8'h00 && vga.green == 8'h00 && vga.blue == 8'h00)
         else stop_on_error($sformatf("FAIL vga after reset: blank_b=%h hsync=%h vsync=%h rgb=%h",
                                      vga.blank_b, vga.hsync, vga.vsync,
                                      {vga.red, vga.green, vga.blue}));
      end
      if (rst_n && rst_d) begin
         if (hs_rise) begin
            assert (hs_low_cnt == hsync_len)
            else stop_on_error($sformatf("FAIL vga.hsync low cycles: got %h expected %h",
                                         hs_low_cnt, hsync_len));
         end
         if (hs_fall && hs_fall_seen) begin
            assert (hs_period == line_cycles)
            else stop_on_error($sformatf("FAIL vga.hsync period: got %h expected %h",
                                         hs_period, line_cycles));
         end
         if (vs_rise) begin
            assert (vs_low_cnt == vsync_len)
            else stop_on_error($sformatf("FAIL vga.vsync low cycles: got %h expected %h",
                                         vs_low_cnt, vsync_len));
         end
         // black in blank and outside the window
         if (!vga.blank_b || (synced && !in_window)) begin
            assert (vga.red == 8'h00 && vga.green == 8'h00 && vga.blue == 8'h00)
            else stop_on_error($sformatf("FAIL vga rgb outside frame: got %h expected 000000",
                                         {vga.red, vga.green, vga.blue}));
         end
         if (synced && in_window && opt_known) begin
            assert ({vga.red[1:0], vga.green[1:0], vga.blue[1:0]} == exp_low)
            else stop_on_error($sformatf("FAIL vga rgb low bits: got %h expected %h",
                                         {vga.red[1:0], vga.green[1:0], vga.blue[1:0]},
                                         exp_low));
         end
         if (opt_known && exp_opt == 2'd2) begin
            assert (vga.green == 8'h00 && vga.blue == 8'h00)
            else stop_on_error($sformatf("FAIL vga.green/blue red only: got %h %h expected 00",
                                         vga.green, vga.blue));
         end
         if (opt_known && exp_opt == 2'd3) begin
            assert (vga.red == vga.green && vga.blue == vga.green)
            else stop_on_error($sformatf("FAIL vga grey: red=%h green=%h blue=%h",
                                         vga.red, vga.green, vga.blue));
         end
         // writes happen exactly in blank, one cycle before blank_b shows it
         assert (req_we_d == !vga.blank_b)
         else stop_on_error($sformatf("FAIL vram_req.we: got %h expected %h",
                                      req_we_d, !vga.blank_b));
         if (vram_req.we) begin
            assert (vram_req.wdata == {4{exp_lane}})
            else stop_on_error($sformatf("FAIL vram_req.wdata: got %h expected %h",
                                         vram_req.wdata, {4{exp_lane}}));
         end
         if (vram_req.we && req_we_d) begin
            assert (vram_req.addr == req_addr_d + 1'b1)
            else stop_on_error($sformatf("FAIL vram_req.addr: got %h expected %h",
                                         vram_req.addr, req_addr_d + 1'b1));
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   // short chatter pulses away from the rest level
   task automatic bounce_button(input int count, input logic rest_level);
      for (int i = 0; i < count; i++) begin
         button0 <= ~rest_level;
         repeat (1 + $unsigned($random(seed)) % 8) @(posedge clk);
         button0 <= rest_level;
         repeat (1 + $unsigned($random(seed)) % 8) @(posedge clk);
      end
   endtask

   task automatic press_option(input logic [1:0] opt);
      integer rnd;
      int bounces;
      rnd = $random(seed);
      bounces = 2 + int'($unsigned($random(seed)) % 3);
      @(posedge clk);
      // upper command bits 01 select the filter
      switch <= {rnd[7:4], 2'b01, opt};
      opt_known <= 1'b0;
      bounce_button(bounces, 1'b1);
      button0 <= 1'b0;
      repeat (4 * video_pkg::DEBOUNCE_CYCLES) @(posedge clk);
      bounce_button(bounces, 1'b0);
      button0 <= 1'b1;
      repeat (4 * video_pkg::DEBOUNCE_CYCLES) @(posedge clk);
      exp_opt <= opt;
      opt_known <= 1'b1;
   endtask

   task automatic wait_frame_start();
      @(posedge clk);
      while (!vs_rise) begin
         @(posedge clk);
      end
   endtask

   initial begin
      seed = 32'h2883;
      rst_n = 1'b0;
      button0 = 1'b1;
      switch = 8'h04;
      exp_opt = 2'd0;
      opt_known = 1'b1;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      // line tracking starts at the first vsync rise
      wait_frame_start();
      for (int opt = 0; opt < 4; opt++) begin
         press_option(2'(opt));
         wait_frame_start();
      end
      $display("sim passed");
      $finish;
   end

   // five frames and some lines of margin
   initial begin
      int limit_ns;
      limit_ns = (5 * int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL)
                  + 64 * int'(video_pkg::H_TOTAL)) * 4;
      #(limit_ns);
      $display("timeout: test did not finish within %0d ns", limit_ns);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

/* filelist.f */
logic/video_pkg.sv
logic/display_timing.sv
logic/vram_fetch.sv
logic/vram_port.sv
logic/filter_command.sv
logic/pixel_filter.sv
logic/video_top.sv
testbench/zbt_model.sv
testbench/tb_video_top.sv

/* Makefile */
TOP := tb_video_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
